//--- files.f
+incdir+include
design/cache_pkg.sv
design/line_array.sv
design/tag_match.sv
design/lru_tracker.sv
design/line_merge.sv
design/cache_ctrl.sv
design/cache_top.sv
test/cache_tb.sv

//--- test/cache_tb.sv
// Testbench for the write-back data cache
// Drives CPU requests, answers line requests from a memory model and checks
// read data, hit latency and memory traffic against a reference model
`timescale 1ns/1ns
`include "cache_defines.svh"

module cache_tb
  import cache_pkg::*;
();

  localparam logic [31:0] seed = 32'hce078e4a;
  // A hit spans acceptance, lookup, done and the sampling edge
  localparam int hit_edges = 4;
  localparam int max_wait = 100;
  localparam int random_ops = 300;

  logic     clk;
  logic     reset;
  logic     access;
  cpu_req_t cpu_req;
  word_t    data_out;
  logic     data_ready;
  logic     mem_enable;
  mem_req_t mem_req;
  logic     mem_data_ready;
  line_t    mem_data_out;

  logic [31:0] rng_state;
  line_t       mem_lines [addr_t];
  logic [7:0]  ref_bytes [addr_t];
  mem_req_t    expected_mem [$];
  logic        ref_valid [`CACHE_LINES];
  logic        ref_dirty [`CACHE_LINES];
  tag_t        ref_tag [`CACHE_LINES];
  int          ref_age [`CACHE_LINES];
  logic        mem_busy;
  int          mem_wait;
  line_t       mem_reply;
  int          writebacks;
  int          hits;
  addr_t       line_addrs [8];

  cache_top cache_top_inst (
    .clk           (clk),
    .reset         (reset),
    .access        (access),
    .cpu_req       (cpu_req),
    .data_out      (data_out),
    .data_ready    (data_ready),
    .mem_enable    (mem_enable),
    .mem_req       (mem_req),
    .mem_data_ready(mem_data_ready),
    .mem_data_out  (mem_data_out)
  );

  always #10 clk = ~clk;

  task automatic end_on_failure();
    $display("TB FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic fail_with_reason(input string what);
    $display("Error at time %0t: %s", $time, what);
    end_on_failure();
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
      end_on_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, got);
      end_on_failure();
    end
  endtask

  // Line data only matters for a write-back
  task automatic check_mem_req(input string name, input mem_req_t got, input mem_req_t exp);
    if (got.op !== exp.op || got.address !== exp.address || (exp.op && got.line !== exp.line))
    begin
      $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
      end_on_failure();
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Content of a line that memory has never been written with
  function automatic line_t fill_line(input addr_t line_addr);
    logic [31:0] s;
    line_t       l;
    s = seed ^ line_addr;
    for (int w = 0; w < `CACHE_WORDS; w++)
    begin
      s = xorshift32(s);
      l[w] = s;
    end
    return l;
  endfunction

  function automatic logic [7:0] ref_byte(input addr_t a);
    line_t l;
    word_t w;
    if (ref_bytes.exists(a))
      return ref_bytes[a];
    l = fill_line({a[31:4], 4'h0});
    w = l[a[3:2]];
    return w[8*a[1:0] +: 8];
  endfunction

  function automatic line_t ref_line(input addr_t line_addr);
    line_t l;
    for (int i = 0; i < 16; i++)
    begin
      l[i >> 2][8*(i % 4) +: 8] = ref_byte(line_addr + i);
    end
    return l;
  endfunction

  // Expected data_out of a read
  function automatic word_t expected_read(input cpu_req_t r);
    addr_t a;
    a = {r.address[31:2], 2'b00};
    if (r.byte_op)
      return {24'h0, ref_byte(r.address)};
    return {ref_byte(a + 3), ref_byte(a + 2), ref_byte(a + 1), ref_byte(a)};
  endfunction

  function automatic void model_write(input cpu_req_t r);
    addr_t a;
    a = {r.address[31:2], 2'b00};
    if (r.byte_op)
      ref_bytes[r.address] = r.wdata[7:0];
    else
    begin
      for (int b = 0; b < 4; b++)
      begin
        ref_bytes[a + b] = r.wdata[8*b +: 8];
      end
    end
  endfunction

  function automatic int model_find(input addr_t a);
    for (int i = 0; i < `CACHE_LINES; i++)
    begin
      if (ref_valid[i] && ref_tag[i] == a[31:4])
        return i;
    end
    return -1;
  endfunction

  function automatic int model_victim();
    for (int i = 0; i < `CACHE_LINES; i++)
    begin
      if (ref_age[i] == 0)
        return i;
    end
    return 0;
  endfunction

  function automatic void model_touch(input int w);
    int old;
    old = ref_age[w];
    for (int i = 0; i < `CACHE_LINES; i++)
    begin
      if (ref_age[i] > old)
        ref_age[i]--;
    end
    ref_age[w] = `CACHE_LINES - 1;
  endfunction

  function automatic cpu_req_t make_req(input logic op, input logic byte_op,
                                        input addr_t address, input word_t wdata);
    cpu_req_t r;
    r.op = op;
    r.byte_op = byte_op;
    r.address = address;
    r.wdata = wdata;
    return r;
  endfunction

  // Predicts the request with the model, then runs it on the DUT and compares
  task automatic run_request(input cpu_req_t r);
    int       way;
    int       cycles;
    logic     hit;
    word_t    exp_data;
    mem_req_t mreq;
    way = model_find(r.address);
    hit = (way >= 0);
    if (!hit)
    begin
      way = model_victim();
      if (ref_valid[way] && ref_dirty[way])
      begin
        mreq.op = 1'b1;
        mreq.address = {ref_tag[way], 4'h0};
        mreq.line = ref_line(mreq.address);
        expected_mem.push_back(mreq);
        writebacks++;
      end
      mreq.op = 1'b0;
      mreq.address = {r.address[31:4], 4'h0};
      mreq.line = '0;
      expected_mem.push_back(mreq);
      ref_valid[way] = 1'b1;
      ref_dirty[way] = 1'b0;
      ref_tag[way] = r.address[31:4];
      model_touch(way);
    end
    else
      hits++;
    // Completion always goes through a hit
    model_touch(way);
    exp_data = expected_read(r);
    if (!r.op)
    begin
      ref_dirty[way] = 1'b1;
      model_write(r);
    end

    @(posedge clk);
    access <= 1'b1;
    cpu_req <= r;
    cycles = 0;
    do
    begin
      @(posedge clk);
      cycles++;
      if (hit)
        check_bit("mem_enable", mem_enable, 1'b0);
      if (cycles > max_wait)
        fail_with_reason("data_ready did not arrive");
    end
    while (!data_ready);
    access <= 1'b0;

    if (hit && cycles != hit_edges)
      fail_with_reason($sformatf("hit took %0d edges to data_ready, expected %0d",
                                 cycles, hit_edges));
    if (r.op)
      check_word("data_out", data_out, exp_data);
    if (expected_mem.size() != 0)
      fail_with_reason("a predicted memory request was never issued");
  endtask

  // Memory model serves one request at a time after 1 to 6 cycles
  always @(posedge clk)
  begin
    if (!reset)
    begin
      if (mem_data_ready)
        mem_data_ready <= 1'b0;
      else if (mem_busy)
      begin
        if (mem_wait == 0)
        begin
          mem_busy = 1'b0;
          mem_data_ready <= 1'b1;
          mem_data_out <= mem_reply;
        end
        else
          mem_wait--;
      end
      else if (mem_enable)
      begin
        if (expected_mem.size() == 0)
          fail_with_reason("memory request that the model did not predict");
        check_mem_req("mem_req", mem_req, expected_mem.pop_front());
        if (mem_req.op)
        begin
          mem_lines[mem_req.address] = mem_req.line;
          mem_reply = '0;
        end
        else if (mem_lines.exists(mem_req.address))
          mem_reply = mem_lines[mem_req.address];
        else
          mem_reply = fill_line(mem_req.address);
        mem_busy = 1'b1;
        mem_wait = next_rand() % 6;
      end
    end
  end

  initial
  begin
    cpu_req_t    r;
    logic [31:0] rnd;
    clk = 1'b0;
    reset = 1'b1;
    access = 1'b0;
    cpu_req = '0;
    mem_data_ready = 1'b0;
    mem_data_out = '0;
    rng_state = seed;
    mem_busy = 1'b0;
    mem_wait = 0;
    mem_reply = '0;
    writebacks = 0;
    hits = 0;
    for (int i = 0; i < `CACHE_LINES; i++)
    begin
      ref_valid[i] = 1'b0;
      ref_dirty[i] = 1'b0;
      ref_tag[i] = '0;
      ref_age[i] = i;
    end
    line_addrs = '{32'h0000_0000, 32'h0000_0010, 32'h0000_1000, 32'h0001_0020,
                   32'h4000_0030, 32'h8000_0040, 32'hdead_bee0, 32'hffff_fff0};

    repeat (2) @(posedge clk);
    reset <= 1'b0;

    // Quiet outputs while access stays low
    repeat (5)
    begin
      @(posedge clk);
      check_bit("data_ready", data_ready, 1'b0);
      check_bit("mem_enable", mem_enable, 1'b0);
    end

    // Byte and word reads around byte and word writes in one line
    run_request(make_req(1'b1, 1'b0, 32'h0000_1004, '0));
    run_request(make_req(1'b0, 1'b0, 32'h0000_1004, 32'h1122_3344));
    for (int b = 0; b < 4; b++)
    begin
      run_request(make_req(1'b1, 1'b1, 32'h0000_1004 + b, '0));
    end
    run_request(make_req(1'b0, 1'b1, 32'h0000_1006, 32'h0000_00ab));
    run_request(make_req(1'b1, 1'b0, 32'h0000_1004, '0));
    run_request(make_req(1'b1, 1'b1, 32'h0000_1006, '0));
    run_request(make_req(1'b1, 1'b1, 32'h0000_100f, '0));

    // Eight lines over four ways keep evicting
    for (int n = 0; n < random_ops; n++)
    begin
      rnd = next_rand();
      r.op = rnd[3];
      r.byte_op = rnd[4];
      r.address = line_addrs[rnd[2:0]];
      r.address[3:2] = rnd[6:5];
      if (rnd[4])
        r.address[1:0] = rnd[8:7];
      r.wdata = next_rand();
      run_request(r);
    end

    if (writebacks == 0 || hits == 0)
      fail_with_reason("random traffic gave no write-back or no hit");
    else
    begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

//--- design/cache_top.sv
// Write-back data cache
// Four fully associative lines between a CPU word port and a line-wide
// memory port, with LRU replacement and write-allocate
`timescale 1ns/1ns
`include "cache_defines.svh"

module cache_top
  import cache_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     access,
  input  cpu_req_t cpu_req,
  output word_t    data_out,
  output logic     data_ready,
  output logic     mem_enable,
  output mem_req_t mem_req,
  input  logic     mem_data_ready,
  input  line_t    mem_data_out
);

  meta_t metas [`CACHE_LINES];
  line_t lines [`CACHE_LINES];
  logic  hit;
  way_t  hit_way;
  way_t  victim;
  logic  meta_we;
  logic  data_we;
  way_t  wr_way;
  meta_t meta_wdata;
  line_t line_wdata;
  logic  touch;
  way_t  touch_way;
  line_t hit_line;
  word_t rdata;
  line_t merged_line;

  // Line under the current request
  assign hit_line = lines[hit_way];

  cache_ctrl cache_ctrl_inst (
    .clk           (clk),
    .reset         (reset),
    .access        (access),
    .cpu_req       (cpu_req),
    .hit           (hit),
    .hit_way       (hit_way),
    .victim        (victim),
    .metas         (metas),
    .lines         (lines),
    .merged_line   (merged_line),
    .rdata         (rdata),
    .meta_we       (meta_we),
    .data_we       (data_we),
    .wr_way        (wr_way),
    .meta_wdata    (meta_wdata),
    .line_wdata    (line_wdata),
    .touch         (touch),
    .touch_way     (touch_way),
    .data_out      (data_out),
    .data_ready    (data_ready),
    .mem_enable    (mem_enable),
    .mem_req       (mem_req),
    .mem_data_ready(mem_data_ready),
    .mem_data_out  (mem_data_out)
  );

  line_array #(.entry_t(meta_t)) meta_array_inst (
    .clk    (clk),
    .reset  (reset),
    .we     (meta_we),
    .way    (wr_way),
    .wdata  (meta_wdata),
    .entries(metas)
  );

  line_array #(.entry_t(line_t)) data_array_inst (
    .clk    (clk),
    .reset  (reset),
    .we     (data_we),
    .way    (wr_way),
    .wdata  (line_wdata),
    .entries(lines)
  );

  tag_match tag_match_inst (
    .addr   (cpu_req.address),
    .metas  (metas),
    .hit    (hit),
    .hit_way(hit_way)
  );

  lru_tracker lru_tracker_inst (
    .clk      (clk),
    .reset    (reset),
    .touch    (touch),
    .touch_way(touch_way),
    .victim   (victim)
  );

  line_merge line_merge_inst (
    .line       (hit_line),
    .req        (cpu_req),
    .rdata      (rdata),
    .merged_line(merged_line)
  );

endmodule

//--- design/cache_ctrl.sv
// Cache controller
// FSM for lookup, dirty write-back, refill and completion toward the CPU,
// and the write controls of the metadata and data arrays
`timescale 1ns/1ns
`include "cache_defines.svh"

module cache_ctrl
  import cache_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     access,
  input  cpu_req_t cpu_req,
  input  logic     hit,
  input  way_t     hit_way,
  input  way_t     victim,
  input  meta_t    metas [`CACHE_LINES],
  input  line_t    lines [`CACHE_LINES],
  input  line_t    merged_line,
  input  word_t    rdata,
  output logic     meta_we,
  output logic     data_we,
  output way_t     wr_way,
  output meta_t    meta_wdata,
  output line_t    line_wdata,
  output logic     touch,
  output way_t     touch_way,
  output word_t    data_out,
  output logic     data_ready,
  output logic     mem_enable,
  output mem_req_t mem_req,
  input  logic     mem_data_ready,
  input  line_t    mem_data_out
);

  ctrl_state_t state;
  cpu_req_t    req_q;
  way_t        way_q;
  meta_t       victim_meta;
  tag_t        req_tag;
  logic        mem_done;

  assign victim_meta = metas[victim];
  assign req_tag = req_q.address[`CACHE_ADDR_W-1:OFFSET_W];
  assign mem_done = mem_enable && mem_data_ready;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state <= IDLE;
      data_ready <= 1'b0;
      mem_enable <= 1'b0;
    end
    else
    begin
      case (state)
        IDLE:
          if (access)
            state <= LOOKUP;
        LOOKUP:
          if (hit)
            state <= DONE;
          else if (victim_meta.valid && victim_meta.dirty)
            state <= WRITEBACK;
          else
            state <= REFILL;
        WRITEBACK, REFILL:
        begin
          // Issue on entry, then wait for memory as long as it takes
          if (!mem_enable)
            mem_enable <= 1'b1;
          else if (mem_data_ready)
          begin
            mem_enable <= 1'b0;
            state <= (state == WRITEBACK) ? REFILL : LOOKUP;
          end
        end
        DONE:
          // First cycle registers the result, second one presents it
          if (!data_ready)
            data_ready <= 1'b1;
          else
          begin
            data_ready <= 1'b0;
            state <= IDLE;
          end
        default:
          state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == IDLE && access)
      req_q <= cpu_req;
    if (state == LOOKUP && !hit)
      way_q <= victim;
    if (state == WRITEBACK && !mem_enable)
      mem_req <= '{op: 1'b1,
                   address: {metas[way_q].tag, {OFFSET_W{1'b0}}},
                   line: lines[way_q]};
    if (state == REFILL && !mem_enable)
      mem_req <= '{op: 1'b0,
                   address: {req_tag, {OFFSET_W{1'b0}}},
                   line: '0};
    if (state == DONE && !data_ready)
      data_out <= rdata;
  end

  // Array writes and LRU touches
  always_comb
  begin
    meta_we = 1'b0;
    data_we = 1'b0;
    wr_way = way_q;
    meta_wdata = metas[way_q];
    line_wdata = mem_data_out;
    touch = 1'b0;
    touch_way = way_q;
    case (state)
      LOOKUP:
        if (hit)
        begin
          touch = 1'b1;
          touch_way = hit_way;
          // Write hit updates the line in place and marks it dirty
          if (!req_q.op)
          begin
            meta_we = 1'b1;
            data_we = 1'b1;
            wr_way = hit_way;
            meta_wdata = metas[hit_way];
            meta_wdata.dirty = 1'b1;
            line_wdata = merged_line;
          end
        end
      REFILL:
        if (mem_done)
        begin
          meta_we = 1'b1;
          data_we = 1'b1;
          meta_wdata = '{valid: 1'b1, dirty: 1'b0, tag: req_tag};
          touch = 1'b1;
        end
      default:
        meta_we = 1'b0;
    endcase
  end

  // Memory request stays put until memory answers
  assert property (@(posedge clk) disable iff (reset)
    mem_enable && !mem_data_ready |=> mem_enable && $stable(mem_req))
    else $error("cache_ctrl: mem_req changed while waiting for memory");

  assert property (@(posedge clk) disable iff (reset) data_ready |-> state == DONE)
    else $error("cache_ctrl: data_ready high in state %s", state.name());

endmodule

//--- design/line_merge.sv
// Line datapath
// Picks the addressed word or zero-extended byte out of a line and builds
// the line that results from a word or byte write
`timescale 1ns/1ns

module line_merge
  import cache_pkg::*;
(
  input  line_t    line,
  input  cpu_req_t req,
  output word_t    rdata,
  output line_t    merged_line
);

  logic [WORD_OFF_W-1:0] word_idx;
  logic [BYTE_OFF_W-1:0] byte_idx;
  word_t                 word_sel;
  logic [7:0]            byte_sel;
  word_t                 merged_word;

  assign word_idx = req.address[OFFSET_W-1:BYTE_OFF_W];
  assign byte_idx = req.address[BYTE_OFF_W-1:0];

  // Little-endian byte lanes
  assign word_sel = line[word_idx];
  assign byte_sel = word_sel[byte_idx*8 +: 8];

  assign rdata = req.byte_op ? {{($bits(word_t) - 8){1'b0}}, byte_sel} : word_sel;

  always_comb
  begin
    merged_word = word_sel;
    if (req.byte_op)
      merged_word[byte_idx*8 +: 8] = req.wdata[7:0];
    else
      merged_word = req.wdata;

    // Other words of the line stay as they were
    merged_line = line;
    merged_line[word_idx] = merged_word;
  end

endmodule

//--- design/lru_tracker.sv
// LRU replacement state
// One age per line, the touched line becomes youngest and age 0 is the victim
`timescale 1ns/1ns
`include "cache_defines.svh"

module lru_tracker
  import cache_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic touch,
  input  way_t touch_way,
  output way_t victim
);

  way_t                    ages [`CACHE_LINES];
  logic [`CACHE_LINES-1:0] age_seen;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      // Line 0 starts as the oldest
      for (int i = 0; i < `CACHE_LINES; i++)
      begin
        ages[i] <= way_t'(i);
      end
    end
    else if (touch)
    begin
      // Lines younger than the touched one move down by one
      for (int i = 0; i < `CACHE_LINES; i++)
      begin
        if (ages[i] > ages[touch_way])
          ages[i] <= ages[i] - 1'b1;
      end
      ages[touch_way] <= way_t'(`CACHE_LINES - 1);
    end
  end

  always_comb
  begin
    victim = '0;
    age_seen = '0;
    for (int i = 0; i < `CACHE_LINES; i++)
    begin
      if (ages[i] == '0)
        victim = way_t'(i);
      age_seen[ages[i]] = 1'b1;
    end
  end

  // Every age value must be held by exactly one line
  assert property (@(posedge clk) disable iff (reset) &age_seen)
    else $error("lru_tracker: ages are not a permutation (%b)", age_seen);

endmodule

//--- design/tag_match.sv
// Tag lookup
// Compares the request tag against every valid line and encodes the hit line
`timescale 1ns/1ns
`include "cache_defines.svh"

module tag_match
  import cache_pkg::*;
(
  input  addr_t addr,
  input  meta_t metas [`CACHE_LINES],
  output logic  hit,
  output way_t  hit_way
);

  tag_t                    req_tag;
  logic [`CACHE_LINES-1:0] match;

  assign req_tag = addr[`CACHE_ADDR_W-1:OFFSET_W];

  always_comb
  begin
    hit_way = '0;
    for (int i = 0; i < `CACHE_LINES; i++)
    begin
      match[i] = metas[i].valid && (metas[i].tag == req_tag);
      if (match[i])
        hit_way = way_t'(i);
    end
  end

  assign hit = |match;

  // A refill only happens on a miss, so a tag lives in one line at most
  always_comb
  begin
    if (!$isunknown(match))
      assert final ($onehot0(match))
        else $error("tag_match: tag %h held by several lines (%b)", req_tag, match);
  end

endmodule

//--- design/line_array.sv
// Per-line storage
// Register file of one entry per cache line with a single write port,
// every entry readable at once
`timescale 1ns/1ns
`include "cache_defines.svh"

module line_array
  import cache_pkg::*;
#(
  parameter type entry_t = line_t
) (
  input  logic   clk,
  input  logic   reset,
  input  logic   we,
  input  way_t   way,
  input  entry_t wdata,
  output entry_t entries [`CACHE_LINES]
);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < `CACHE_LINES; i++)
      begin
        entries[i] <= '0;
      end
    end
    else if (we)
    begin
      entries[way] <= wdata;
    end
  end

endmodule

//--- design/cache_pkg.sv
// Cache types
// Address, word and line types, line metadata and the CPU and memory requests
`include "cache_defines.svh"

package cache_pkg;

  // Offset fields inside a byte address
  localparam int BYTE_OFF_W = $clog2(`CACHE_WORD_W / 8);
  localparam int WORD_OFF_W = $clog2(`CACHE_WORDS);
  localparam int OFFSET_W = BYTE_OFF_W + WORD_OFF_W;
  localparam int TAG_W = `CACHE_ADDR_W - OFFSET_W;

  typedef logic [`CACHE_ADDR_W-1:0] addr_t;
  typedef logic [`CACHE_WORD_W-1:0] word_t;
  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [$clog2(`CACHE_LINES)-1:0] way_t;

  // Word 0 sits in the low bits
  typedef word_t [`CACHE_WORDS-1:0] line_t;

  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } meta_t;

  // op is 1 for a read
  typedef struct packed {
    logic  op;
    logic  byte_op;
    addr_t address;
    word_t wdata;
  } cpu_req_t;

  // op is 1 for a write, address is line aligned
  typedef struct packed {
    logic  op;
    addr_t address;
    line_t line;
  } mem_req_t;

  typedef enum logic [2:0] {IDLE, LOOKUP, WRITEBACK, REFILL, DONE} ctrl_state_t;

endpackage

//--- include/cache_defines.svh
// Cache geometry macros
// Address and word widths, line count and words per line
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Byte address width
`define CACHE_ADDR_W 32

// CPU data word width
`define CACHE_WORD_W 32

// Number of fully associative lines
`define CACHE_LINES 4

// Words held by one line
`define CACHE_WORDS 4

`endif
